/* verilog/irc_pkg.sv */
// --------------------------------------------------------------------
// shared widths, bus types and arbitration states for the interrupt
// controller; modules pull these in with a wildcard import
// --------------------------------------------------------------------

`default_nettype none

package irc_pkg;

    // default sizing, passed down from the top level
    parameter int NUM_FACTORS_DEFAULT     = 4;
    parameter int FACTOR_ID_WIDTH_DEFAULT = 2;
    parameter int PRIORITY_WIDTH_DEFAULT  = 3;

    // register bus
    parameter int DATA_WIDTH = 32;
    parameter int ADR_WIDTH  = 5;

    typedef logic [FACTOR_ID_WIDTH_DEFAULT-1:0] factor_id_t;
    // lower value is more urgent
    typedef logic [PRIORITY_WIDTH_DEFAULT-1:0]  priority_t;
    typedef logic [DATA_WIDTH-1:0]              bus_data_t;
    typedef logic [ADR_WIDTH-1:0]               bus_adr_t;

    // phases of one arbitration round
    typedef enum logic [2:0] {
        IDLE,
        LAUNCH,
        SHIFT,
        LATCH,
        CLEAR
    } arb_state_t;

endpackage

`default_nettype wire

/* verilog/irc_reg_if.sv */
// --------------------------------------------------------------------
// register access bundle from the bus decoder to one interrupt factor
// --------------------------------------------------------------------

`default_nettype none

interface irc_reg_if import irc_pkg::*; ();

    // register offset inside the factor
    logic [1:0] adr;
    bus_data_t  wdat;
    logic       we;
    // already qualified by the factor select
    logic       stb;
    bus_data_t  rdat;

    modport ctrl (
        output adr,
        output wdat,
        output we,
        output stb,
        input  rdat
    );

    modport factor (
        input  adr,
        input  wdat,
        input  we,
        input  stb,
        output rdat
    );

endinterface

`default_nettype wire

/* verilog/irc_factor.sv */
// --------------------------------------------------------------------
// one interrupt source: enable, sticky pending and priority registers
// plus the serial sender that competes on the wired-AND sense line
// --------------------------------------------------------------------

`default_nettype none

module irc_factor import irc_pkg::*; #(
    parameter int FACTOR_ID_WIDTH = FACTOR_ID_WIDTH_DEFAULT,
    parameter int PRIORITY_WIDTH  = PRIORITY_WIDTH_DEFAULT
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire factor_id_t factor_id_i,
    input  wire logic       irq_i,
    input  wire logic       request_reset_i,
    input  wire logic       request_start_i,
    input  wire logic       sense_i,
    output logic            send_o,
    irc_reg_if.factor       regs
);

    localparam int PACKET_WIDTH = PRIORITY_WIDTH + FACTOR_ID_WIDTH;

    logic                      enable_q;
    logic                      pending_q;
    logic [PRIORITY_WIDTH-1:0] priority_q;
    logic [PACKET_WIDTH-1:0]   packet_q;
    logic                      request;
    logic                      wr;

    assign request = enable_q & pending_q;
    assign wr      = regs.stb & regs.we;

    // --------------------------------------------------------------------
    // registers
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q   <= 1'b0;
            pending_q  <= 1'b0;
            priority_q <= '0;
        end else begin
            if (wr && regs.adr == 2'd0) begin
                enable_q <= regs.wdat[0];
            end
            // a live irq wins over a bus clear
            if (irq_i) begin
                pending_q <= 1'b1;
            end else if (wr && regs.adr == 2'd1) begin
                pending_q <= regs.wdat[0];
            end
            if (wr && regs.adr == 2'd3) begin
                priority_q <= regs.wdat[PRIORITY_WIDTH-1:0];
            end
        end
    end

    // read data, zero when not addressed
    always_comb begin
        regs.rdat = '0;
        if (regs.stb) begin
            case (regs.adr)
                2'd0: regs.rdat[0] = enable_q;
                2'd1: regs.rdat[0] = pending_q;
                2'd2: regs.rdat[0] = irq_i;
                default: regs.rdat[PRIORITY_WIDTH-1:0] = priority_q;
            endcase
        end
    end

    // --------------------------------------------------------------------
    // serial packet sender, priority then id, msb first
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            packet_q <= '1;
        end else if (request_reset_i || (send_o != sense_i)) begin
            // lost the bit or round over, go idle
            packet_q <= '1;
        end else if (request_start_i && request) begin
            packet_q <= {priority_q, FACTOR_ID_WIDTH'(factor_id_i)};
        end else begin
            packet_q <= {packet_q[PACKET_WIDTH-2:0], 1'b1};
        end
    end

    // a 1 is recessive on the shared line
    assign send_o = packet_q[PACKET_WIDTH-1];

endmodule

`default_nettype wire

/* verilog/irc_arbiter_fsm.sv */
// --------------------------------------------------------------------
// round sequencer: launch, shift the packet bits, latch, clear, and
// repeat while the global enable is set
// --------------------------------------------------------------------

`default_nettype none

module irc_arbiter_fsm import irc_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic enable_i,
    input  wire logic last_i,
    output logic      request_start_o,
    output logic      request_reset_o,
    output logic      count_load_o,
    output logic      count_en_o,
    output logic      latch_o
);

    arb_state_t state_q;
    arb_state_t state_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (enable_i) begin
                    state_d = LAUNCH;
                end
            end
            LAUNCH: state_d = SHIFT;
            SHIFT: begin
                if (last_i) begin
                    state_d = LATCH;
                end
            end
            LATCH: state_d = CLEAR;
            // back to back rounds while enabled
            CLEAR: state_d = enable_i ? LAUNCH : IDLE;
            default: state_d = IDLE;
        endcase
    end

    // moore outputs, one per phase
    assign request_start_o = (state_q == LAUNCH);
    assign count_load_o    = (state_q == LAUNCH);
    assign count_en_o      = (state_q == SHIFT);
    assign latch_o         = (state_q == LATCH);
    assign request_reset_o = (state_q == CLEAR);

endmodule

`default_nettype wire

/* verilog/irc_bit_counter.sv */
// --------------------------------------------------------------------
// down counter for the shift phase; last_o marks the final packet bit
// --------------------------------------------------------------------

`default_nettype none

module irc_bit_counter #(
    // number of bits shifted per round
    parameter int COUNT_WIDTH = 5
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic load_i,
    input  wire logic count_en_i,
    output logic      last_o
);

    localparam int CNT_W = (COUNT_WIDTH > 1) ? $clog2(COUNT_WIDTH) : 1;

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= CNT_W'(COUNT_WIDTH - 1);
        end else if (count_en_i && count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign last_o = count_en_i && (count_q == '0);

endmodule

`default_nettype wire

/* verilog/irc_ctrl_regs.sv */
// --------------------------------------------------------------------
// bus decode and read mux, global enable, wired-AND sense, and capture
// of each round's winning packet into the result register
// --------------------------------------------------------------------

`default_nettype none

module irc_ctrl_regs import irc_pkg::*; #(
    parameter int NUM_FACTORS     = NUM_FACTORS_DEFAULT,
    parameter int FACTOR_ID_WIDTH = FACTOR_ID_WIDTH_DEFAULT,
    parameter int PRIORITY_WIDTH  = PRIORITY_WIDTH_DEFAULT
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire bus_adr_t               wb_adr_i,
    input  wire bus_data_t              wb_dat_i,
    input  wire logic                   wb_we_i,
    input  wire logic                   wb_stb_i,
    input  wire logic [NUM_FACTORS-1:0] send_i,
    input  wire logic                   latch_i,
    input  wire logic                   shift_i,
    output bus_data_t                   wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        sense_o,
    output logic                        enable_o,
    output logic                        irq_o,
    output factor_id_t                  irq_id_o,
    output priority_t                   irq_priority_o,
    irc_reg_if.ctrl                     regs [NUM_FACTORS]
);

    localparam int PACKET_WIDTH = PRIORITY_WIDTH + FACTOR_ID_WIDTH;

    bus_data_t               factor_rdat [NUM_FACTORS];
    logic                    ctrl_space;
    logic                    enable_wr;
    logic                    enable_q;
    logic [PACKET_WIDTH-1:0] capture_q;
    logic                    valid_q;
    factor_id_t              id_q;
    priority_t               priority_q;

    // --------------------------------------------------------------------
    // address decode, bit 4 picks controller space
    // --------------------------------------------------------------------
    assign ctrl_space = wb_adr_i[4];
    assign enable_wr  = wb_stb_i & wb_we_i & ctrl_space & (wb_adr_i[3:0] == 4'd0);

    for (genvar i = 0; i < NUM_FACTORS; i++) begin : g_factor_bus
        assign regs[i].adr  = wb_adr_i[1:0];
        assign regs[i].wdat = wb_dat_i;
        assign regs[i].we   = wb_we_i;
        assign regs[i].stb  = wb_stb_i & ~ctrl_space & (wb_adr_i[3:2] == 2'(i));
        assign factor_rdat[i] = regs[i].rdat;
    end

    // unselected factors return zero, so an OR makes the mux
    always_comb begin
        wb_dat_o = '0;
        if (wb_stb_i) begin
            if (!ctrl_space) begin
                for (int i = 0; i < NUM_FACTORS; i++) begin
                    wb_dat_o = wb_dat_o | factor_rdat[i];
                end
            end else if (wb_adr_i[3:0] == 4'd0) begin
                wb_dat_o[0] = enable_q;
            end else if (wb_adr_i[3:0] == 4'd1) begin
                wb_dat_o[8]   = valid_q;
                wb_dat_o[4:2] = priority_q;
                wb_dat_o[1:0] = id_q;
            end
        end
    end

    // no wait states
    assign wb_ack_o = wb_stb_i;

    // --------------------------------------------------------------------
    // global enable and the shared sense line
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q <= 1'b0;
        end else if (enable_wr) begin
            enable_q <= wb_dat_i[0];
        end
    end

    assign enable_o = enable_q;
    assign sense_o  = &send_i;

    // --------------------------------------------------------------------
    // capture and result
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (shift_i) begin
            capture_q <= {capture_q[PACKET_WIDTH-2:0], sense_o};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            id_q       <= '0;
            priority_q <= '0;
        end else if (enable_wr && !wb_dat_i[0]) begin
            // disabling drops the request right away
            valid_q <= 1'b0;
        end else if (latch_i) begin
            // all ones is the idle pattern, nobody sent
            valid_q    <= enable_q & ~(&capture_q);
            id_q       <= factor_id_t'(capture_q[FACTOR_ID_WIDTH-1:0]);
            priority_q <= priority_t'(capture_q[PACKET_WIDTH-1:FACTOR_ID_WIDTH]);
        end
    end

    assign irq_o          = valid_q;
    assign irq_id_o       = id_q;
    assign irq_priority_o = priority_q;

endmodule

`default_nettype wire

/* verilog/irc_top.sv */
// --------------------------------------------------------------------
// interrupt controller top: register block, round sequencer, bit
// counter and one factor per interrupt input
// --------------------------------------------------------------------

`default_nettype none

module irc_top import irc_pkg::*; #(
    parameter int NUM_FACTORS     = NUM_FACTORS_DEFAULT,
    parameter int FACTOR_ID_WIDTH = FACTOR_ID_WIDTH_DEFAULT,
    parameter int PRIORITY_WIDTH  = PRIORITY_WIDTH_DEFAULT
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [NUM_FACTORS-1:0] irq_i,
    input  wire bus_adr_t               wb_adr_i,
    input  wire bus_data_t              wb_dat_i,
    input  wire logic                   wb_we_i,
    input  wire logic                   wb_stb_i,
    output bus_data_t                   wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        irq_o,
    output factor_id_t                  irq_id_o,
    output priority_t                   irq_priority_o
);

    localparam int PACKET_WIDTH = PRIORITY_WIDTH + FACTOR_ID_WIDTH;

    logic [NUM_FACTORS-1:0] send;
    logic                   sense;
    logic                   enable;
    logic                   request_start;
    logic                   request_reset;
    logic                   count_load;
    logic                   count_en;
    logic                   last;
    logic                   latch;

    irc_reg_if reg_if [NUM_FACTORS] ();

    irc_ctrl_regs #(
        .NUM_FACTORS     (NUM_FACTORS),
        .FACTOR_ID_WIDTH (FACTOR_ID_WIDTH),
        .PRIORITY_WIDTH  (PRIORITY_WIDTH)
    ) ctrl_regs_inst (
        .clk            (clk),
        .reset          (reset),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_we_i        (wb_we_i),
        .wb_stb_i       (wb_stb_i),
        .send_i         (send),
        .latch_i        (latch),
        .shift_i        (count_en),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .sense_o        (sense),
        .enable_o       (enable),
        .irq_o          (irq_o),
        .irq_id_o       (irq_id_o),
        .irq_priority_o (irq_priority_o),
        .regs           (reg_if)
    );

    irc_arbiter_fsm arbiter_fsm_inst (
        .clk             (clk),
        .reset           (reset),
        .enable_i        (enable),
        .last_i          (last),
        .request_start_o (request_start),
        .request_reset_o (request_reset),
        .count_load_o    (count_load),
        .count_en_o      (count_en),
        .latch_o         (latch)
    );

    irc_bit_counter #(
        .COUNT_WIDTH (PACKET_WIDTH)
    ) bit_counter_inst (
        .clk        (clk),
        .reset      (reset),
        .load_i     (count_load),
        .count_en_i (count_en),
        .last_o     (last)
    );

    for (genvar i = 0; i < NUM_FACTORS; i++) begin : g_factor
        irc_factor #(
            .FACTOR_ID_WIDTH (FACTOR_ID_WIDTH),
            .PRIORITY_WIDTH  (PRIORITY_WIDTH)
        ) factor_inst (
            .clk             (clk),
            .reset           (reset),
            .factor_id_i     (factor_id_t'(i)),
            .irq_i           (irq_i[i]),
            .request_reset_i (request_reset),
            .request_start_i (request_start),
            .sense_i         (sense),
            .send_o          (send[i]),
            .regs            (reg_if[i])
        );
    end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
// ----------------------------------------------------------------------
// testbench clock with an 8 ns period and a synchronous reset that is
// held high for the first four rising edges
// ----------------------------------------------------------------------

`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_o <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* sim/irc_tb.sv */
// ----------------------------------------------------------------------
// testbench for the interrupt controller with bus stimulus, a reference
// arbitration model and a queue-fed checking process
// ----------------------------------------------------------------------

`default_nettype none

module irc_tb import irc_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int       NF             = NUM_FACTORS_DEFAULT;
    localparam int       PW             = PRIORITY_WIDTH_DEFAULT;
    localparam int       TIMEOUT_CYCLES = 32;
    localparam bus_adr_t ENABLE_ADR     = 5'h10;
    localparam bus_adr_t RESULT_ADR     = 5'h11;
    localparam int       REG_ENABLE     = 0;
    localparam int       REG_PENDING    = 1;
    localparam int       REG_STATUS     = 2;
    localparam int       REG_PRIORITY   = 3;

    logic       clk;
    logic       reset;
    logic [NF-1:0] irq;
    bus_adr_t   wb_adr;
    bus_data_t  wb_dat_in;
    logic       wb_we;
    logic       wb_stb;
    bus_data_t  wb_dat_out;
    logic       wb_ack;
    logic       irq_out;
    factor_id_t irq_id;
    priority_t  irq_prio;

    // model of what was written to the factors
    logic [NF-1:0]      en_m;
    logic [NF-1:0]      pend_m;
    priority_t [NF-1:0] prio_m;

    integer seed         = 82;
    int     checks_total = 0;
    int     errors_total = 0;
    int     tests_run    = 0;
    int     test_base    = 0;

    // pending comparisons for the checking process
    string     chk_name_q [$];
    bus_data_t chk_exp_q [$];
    bus_data_t chk_act_q [$];
    time       chk_time_q [$];

    tb_clock_gen clock_gen_inst (
        .clk_o   (clk),
        .reset_o (reset)
    );

    irc_top irc_top_inst (
        .clk            (clk),
        .reset          (reset),
        .irq_i          (irq),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_in),
        .wb_we_i        (wb_we),
        .wb_stb_i       (wb_stb),
        .wb_dat_o       (wb_dat_out),
        .wb_ack_o       (wb_ack),
        .irq_o          (irq_out),
        .irq_id_o       (irq_id),
        .irq_priority_o (irq_prio)
    );

    // ----------------------------------------------------------------------
    // reference model and helpers
    // ----------------------------------------------------------------------

    // returns {valid, priority, id}
    function automatic logic [5:0] best_request(
        input logic [NF-1:0]      en,
        input logic [NF-1:0]      pend,
        input priority_t [NF-1:0] prios
    );
        logic       found;
        priority_t  best_p;
        factor_id_t best_id;
        found   = 1'b0;
        best_p  = '1;
        best_id = '1;
        for (int f = 0; f < NF; f++) begin
            // strict compare keeps the lower id on a tie
            if (en[f] && pend[f] && (!found || prios[f] < best_p)) begin
                found   = 1'b1;
                best_p  = prios[f];
                best_id = factor_id_t'(f);
            end
        end
        // an all ones packet looks like an idle line
        if (found && best_p == '1 && best_id == '1) begin
            found = 1'b0;
        end
        return {found, best_p, best_id};
    endfunction

    function automatic bus_adr_t factor_adr(input int f, input int r);
        return {1'b0, f[1:0], r[1:0]};
    endfunction

    task automatic expect_value(input string name, input bus_data_t exp, input bus_data_t act);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp);
        chk_act_q.push_back(act);
        chk_time_q.push_back($time);
    endtask

    task automatic bus_write(input bus_adr_t adr, input bus_data_t dat);
        @(posedge clk);
        wb_adr    <= adr;
        wb_dat_in <= dat;
        wb_we     <= 1'b1;
        wb_stb    <= 1'b1;
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input bus_adr_t adr, output bus_data_t dat);
        @(posedge clk);
        wb_adr <= adr;
        wb_we  <= 1'b0;
        wb_stb <= 1'b1;
        @(negedge clk);
        dat = wb_dat_out;
        expect_value("wb_ack_o", 32'd1, 32'(wb_ack));
        @(posedge clk);
        wb_stb <= 1'b0;
    endtask

    task automatic check_read(input string name, input bus_adr_t adr, input bus_data_t exp);
        bus_data_t d;
        bus_read(adr, d);
        expect_value(name, exp, d);
    endtask

    task automatic write_factor(input int f, input int r, input bus_data_t val);
        bus_write(factor_adr(f, r), val);
        case (r)
            REG_ENABLE:   en_m[f] = val[0];
            // a live irq keeps pending set
            REG_PENDING:  pend_m[f] = val[0] | irq[f];
            REG_PRIORITY: prio_m[f] = val[PW-1:0];
            default: ;
        endcase
    endtask

    task automatic wait_for_irq(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (irq_out !== level && n < TIMEOUT_CYCLES);
        if (irq_out !== level) begin
            $display("timeout at %0t: irq_o did not become %0b within %0d cycles",
                     $time, level, TIMEOUT_CYCLES);
            errors_total++;
        end
    endtask

    task automatic compare_result();
        logic [5:0] exp_r;
        bus_data_t  d;
        exp_r = best_request(en_m, pend_m, prio_m);
        expect_value("irq_o", 32'(exp_r[5]), 32'(irq_out));
        if (exp_r[5]) begin
            expect_value("irq_id_o", 32'(exp_r[1:0]), 32'(irq_id));
            expect_value("irq_priority_o", 32'(exp_r[4:2]), 32'(irq_prio));
        end
        bus_read(RESULT_ADR, d);
        expect_value("wb_dat_o[8]", 32'(exp_r[5]), 32'(d[8]));
        if (exp_r[5]) begin
            expect_value("wb_dat_o[4:2]", 32'(exp_r[4:2]), 32'(d[4:2]));
            expect_value("wb_dat_o[1:0]", 32'(exp_r[1:0]), 32'(d[1:0]));
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (chk_name_q.size() != 0 && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (chk_name_q.size() != 0) begin
            $display("checker did not drain its queue for test %s", name);
            errors_total++;
        end
        tests_run++;
        if (errors_total == test_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     errors_total - test_base);
        end
        test_base = errors_total;
    endtask

    // ----------------------------------------------------------------------
    // checking process
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : compare_proc
        string     name;
        bus_data_t exp;
        bus_data_t act;
        time       t;
        while (chk_name_q.size() > 0) begin
            name = chk_name_q.pop_front();
            exp  = chk_exp_q.pop_front();
            act  = chk_act_q.pop_front();
            t    = chk_time_q.pop_front();
            checks_total++;
            if (exp !== act) begin
                $display("error at %0t: %s expected %0h got %0h", t, name, exp, act);
                errors_total++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin : stimulus
        bus_data_t d;
        priority_t p;
        int        n;
        irq       <= '0;
        wb_adr    <= '0;
        wb_dat_in <= '0;
        wb_we     <= 1'b0;
        wb_stb    <= 1'b0;
        en_m   = '0;
        pend_m = '0;
        prio_m = '0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset && n < 20);
        if (reset) begin
            $display("reset never released");
            errors_total++;
        end

        // reset values and zero reads of every register
        @(negedge clk);
        expect_value("irq_o", 32'd0, 32'(irq_out));
        expect_value("wb_ack_o", 32'd0, 32'(wb_ack));
        for (int f = 0; f < NF; f++) begin
            for (int r = 0; r < 4; r++) begin
                check_read("wb_dat_o", factor_adr(f, r), 32'd0);
            end
        end
        check_read("wb_dat_o", ENABLE_ADR, 32'd0);
        check_read("wb_dat_o", RESULT_ADR, 32'd0);
        @(negedge clk);
        expect_value("wb_ack_o", 32'd0, 32'(wb_ack));
        finish_test("reset state");

        // readback of enable, priority and status
        for (int f = 0; f < NF; f++) begin
            p = priority_t'($random(seed));
            write_factor(f, REG_ENABLE, 32'd1);
            check_read("wb_dat_o", factor_adr(f, REG_ENABLE), 32'd1);
            write_factor(f, REG_PRIORITY, 32'(p));
            check_read("wb_dat_o", factor_adr(f, REG_PRIORITY), 32'(p));
            write_factor(f, REG_ENABLE, 32'd0);
            check_read("wb_dat_o", factor_adr(f, REG_ENABLE), 32'd0);
            @(posedge clk);
            irq[f] <= 1'b1;
            check_read("wb_dat_o", factor_adr(f, REG_STATUS), 32'd1);
            @(posedge clk);
            irq[f] <= 1'b0;
            check_read("wb_dat_o", factor_adr(f, REG_STATUS), 32'd0);
            write_factor(f, REG_PENDING, 32'd0);
        end
        finish_test("register readback");

        // sticky pending on factor 1
        @(posedge clk);
        irq[1] <= 1'b1;
        @(posedge clk);
        irq[1] <= 1'b0;
        pend_m[1] = 1'b1;
        check_read("wb_dat_o", factor_adr(1, REG_PENDING), 32'd1);
        write_factor(1, REG_PENDING, 32'd0);
        check_read("wb_dat_o", factor_adr(1, REG_PENDING), 32'd0);
        // irq held through the write strobe and released before the read
        @(posedge clk);
        irq[1] <= 1'b1;
        write_factor(1, REG_PENDING, 32'd0);
        irq[1] <= 1'b0;
        check_read("wb_dat_o", factor_adr(1, REG_PENDING), 32'd1);
        write_factor(1, REG_PENDING, 32'd0);
        check_read("wb_dat_o", factor_adr(1, REG_PENDING), 32'd0);
        finish_test("sticky pending");

        // one source wins alone and then goes away
        bus_write(ENABLE_ADR, 32'd1);
        for (int f = 0; f < NF; f++) begin
            write_factor(f, REG_ENABLE, 32'd0);
            write_factor(f, REG_PENDING, 32'd0);
        end
        write_factor(2, REG_PRIORITY, 32'd5);
        write_factor(2, REG_ENABLE, 32'd1);
        @(posedge clk);
        irq[2] <= 1'b1;
        @(posedge clk);
        irq[2] <= 1'b0;
        pend_m[2] = 1'b1;
        wait_for_irq(1'b1);
        expect_value("irq_id_o", 32'd2, 32'(irq_id));
        expect_value("irq_priority_o", 32'd5, 32'(irq_prio));
        write_factor(2, REG_PENDING, 32'd0);
        wait_for_irq(1'b0);
        finish_test("single source");

        // random arbitration with a forced priority tie every fourth trial
        for (int t = 0; t < 40; t++) begin
            p = priority_t'($random(seed));
            for (int f = 0; f < NF; f++) begin
                d = $random(seed);
                write_factor(f, REG_ENABLE, {31'd0, d[0] | d[2]});
                write_factor(f, REG_PENDING, {31'd0, d[1] | d[3]});
                write_factor(f, REG_PRIORITY, (t % 4 == 0) ? {29'd0, p} : {29'd0, d[6:4]});
            end
            repeat (16) @(posedge clk);
            @(negedge clk);
            compare_result();
        end
        finish_test("random arbitration");

        // global enable off and on again with ids 1 and 3 tied
        write_factor(0, REG_PRIORITY, 32'd6);
        write_factor(1, REG_PRIORITY, 32'd2);
        write_factor(3, REG_PRIORITY, 32'd2);
        for (int f = 0; f < NF; f++) begin
            write_factor(f, REG_ENABLE, {31'd0, f != 2});
            write_factor(f, REG_PENDING, 32'd1);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        compare_result();
        bus_write(ENABLE_ADR, 32'd0);
        @(negedge clk);
        expect_value("irq_o", 32'd0, 32'(irq_out));
        bus_read(RESULT_ADR, d);
        expect_value("wb_dat_o[8]", 32'd0, 32'(d[8]));
        repeat (16) @(posedge clk);
        @(negedge clk);
        expect_value("irq_o", 32'd0, 32'(irq_out));
        bus_write(ENABLE_ADR, 32'd1);
        wait_for_irq(1'b1);
        compare_result();
        finish_test("global enable");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks_total, errors_total);
        if (errors_total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/irc_pkg.sv
verilog/irc_reg_if.sv
verilog/irc_factor.sv
verilog/irc_arbiter_fsm.sv
verilog/irc_bit_counter.sv
verilog/irc_ctrl_regs.sv
verilog/irc_top.sv
sim/tb_clock_gen.sv
sim/irc_tb.sv

/* run.sh */
#!/bin/sh
# build the interrupt controller testbench with Verilator and run it;
# the exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module irc_tb -f all.f -o irc_sim || exit 1

out=$(./obj_dir/irc_sim)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
